// ==== logic/ht_macros.svh ====
// ==========================================================================
// Health test sizing macros
// Widths shared by the repetition-count test and the alert control
// ==========================================================================

`ifndef HT_MACROS_SVH
`define HT_MACROS_SVH

// Width of counts, thresholds and the watermark
`define REG_WIDTH 16

// Number of raw noise bit lanes delivered per sample
`define RNG_BUS_WIDTH 4

`endif

// ==== logic/ht_pkg.sv ====
// ==========================================================================
// Health test package
// Shared vector types, packed structs and the alert FSM encoding
// ==========================================================================

`default_nettype none

`include "ht_macros.svh"

package ht_pkg;

  typedef logic [`REG_WIDTH-1:0]     reg_val_t;
  typedef logic [`RNG_BUS_WIDTH-1:0] rng_bits_t;

  // One raw sample with its strobe
  typedef struct packed {
    logic      valid;
    rng_bits_t bits;
  } rng_sample_t;

  // Health test outputs toward the alert control
  typedef struct packed {
    reg_val_t test_cnt;
    logic     fail_pulse;
    logic     count_err;
  } ht_status_t;

  typedef reg_val_t [`RNG_BUS_WIDTH-1:0] lane_cnts_t;

  typedef enum logic {
    ALERT_IDLE,
    ALERT_FIRED
  } alert_state_e;

endpackage

`default_nettype wire

// ==== logic/ht_hardened_counter.sv ====
// ==========================================================================
// Hardened up counter
// Settable, saturating count held twice: once as is and once inverted,
// each with its own next-state logic. Any disagreement raises err_o.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module ht_hardened_counter (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             set_i,
  input  ht_pkg::reg_val_t set_cnt_i,
  input  logic             incr_en_i,
  output ht_pkg::reg_val_t cnt_o,
  output logic             err_o
);

  import ht_pkg::*;

  reg_val_t cnt_d, cnt_q;
  reg_val_t cnt_inv_d, cnt_inv_q;

  // Primary count, set wins over increment
  always_comb begin
    cnt_d = cnt_q;
    if (set_i) begin
      cnt_d = set_cnt_i;
    end else if (incr_en_i && (cnt_q != '1)) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  // Inverted copy counts down, built from its own register
  always_comb begin
    cnt_inv_d = cnt_inv_q;
    if (set_i) begin
      cnt_inv_d = ~set_cnt_i;
    end else if (incr_en_i && (cnt_inv_q != '0)) begin
      cnt_inv_d = cnt_inv_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      cnt_inv_q <= '1;
    end else begin
      cnt_q     <= cnt_d;
      cnt_inv_q <= cnt_inv_d;
    end
  end

  assign cnt_o = cnt_q;

  // A flipped bit in either register shows up here
  assign err_o = (cnt_q != ~cnt_inv_q);

  // Both copies must track each other across every update
  a_no_count_err: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !err_o
  ) else $error("hardened counter copies disagree");

endmodule

`default_nettype wire

// ==== logic/ht_max_tree.sv ====
// ==========================================================================
// Max tree
// Combinational binary tree returning the largest of the lane counts
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "ht_macros.svh"

module ht_max_tree (
  input  ht_pkg::lane_cnts_t values_i,
  output ht_pkg::reg_val_t   max_value_o
);

  import ht_pkg::*;

  localparam int NumSrc    = `RNG_BUS_WIDTH;
  localparam int NumLevels = $clog2(NumSrc);

  // Node values per level, level 0 holds the inputs
  reg_val_t lvl [NumLevels+1][NumSrc];

  for (genvar i = 0; i < NumSrc; i++) begin : gen_leaf
    assign lvl[0][i] = values_i[i];
  end

  for (genvar l = 0; l < NumLevels; l++) begin : gen_level
    // Live entries at the input of this level
    localparam int NumIn = (NumSrc + (1 << l) - 1) >> l;

    for (genvar k = 0; k < NumSrc; k++) begin : gen_node
      if (2 * k + 1 < NumIn) begin : gen_cmp
        assign lvl[l+1][k] = (lvl[l][2*k] >= lvl[l][2*k+1]) ?
                             lvl[l][2*k] : lvl[l][2*k+1];
      end else if (2 * k < NumIn) begin : gen_pass
        // Odd one out moves up unchanged
        assign lvl[l+1][k] = lvl[l][2*k];
      end else begin : gen_unused
        assign lvl[l+1][k] = '0;
      end
    end
  end

  // Root of the tree
  assign max_value_o = lvl[NumLevels][0];

endmodule

`default_nettype wire

// ==== logic/ht_repcnt.sv ====
// ==========================================================================
// Repetition-count health test
// Per lane run counters of equal consecutive samples, starting at one.
// Reports the largest count and pulses on a threshold hit.
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "ht_macros.svh"

module ht_repcnt (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ht_pkg::rng_sample_t sample_i,
  input  logic                active_i,
  input  logic                clear_i,
  input  ht_pkg::reg_val_t    thresh_i,
  output ht_pkg::ht_status_t  status_o
);

  import ht_pkg::*;

  rng_bits_t  prev_sample_q;
  logic       strobe_q;
  rng_bits_t  lane_match;
  rng_bits_t  lane_mismatch;
  rng_bits_t  lane_fail;
  rng_bits_t  lane_err;
  lane_cnts_t lane_cnts;
  reg_val_t   max_cnt;
  logic       restart;

  // Inactive or cleared test restarts every lane
  assign restart = !active_i || clear_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_sample_q <= '0;
      strobe_q      <= 1'b0;
    end else begin
      strobe_q <= sample_i.valid;
      if (restart) begin
        prev_sample_q <= '0;
      end else if (sample_i.valid) begin
        prev_sample_q <= sample_i.bits;
      end
    end
  end

  for (genvar i = 0; i < `RNG_BUS_WIDTH; i++) begin : gen_lane
    assign lane_match[i]    = sample_i.valid && (prev_sample_q[i] == sample_i.bits[i]);
    assign lane_mismatch[i] = sample_i.valid && (prev_sample_q[i] != sample_i.bits[i]);

    ht_hardened_counter u_lane_cnt (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .set_i     (restart || lane_mismatch[i]),
      .set_cnt_i (reg_val_t'(1)),
      .incr_en_i (lane_match[i]),
      .cnt_o     (lane_cnts[i]),
      .err_o     (lane_err[i])
    );

    assign lane_fail[i] = (lane_cnts[i] >= thresh_i);
  end

  ht_max_tree u_max_tree (
    .values_i    (lane_cnts),
    .max_value_o (max_cnt)
  );

  // Counts are judged once, in the cycle right after they moved
  assign status_o.test_cnt   = max_cnt;
  assign status_o.fail_pulse = active_i && strobe_q && (|lane_fail);
  assign status_o.count_err  = |lane_err;

  // Every pulse needs a strobe one cycle earlier and a maximum at the threshold
  a_pulse_after_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    status_o.fail_pulse |-> $past(sample_i.valid) && (max_cnt >= thresh_i)
  ) else $error("failure pulse without a preceding strobe or a count at the threshold");

endmodule

`default_nettype wire

// ==== logic/ht_alert_ctrl.sv ====
// ==========================================================================
// Health test alert control
// Counts failure pulses, tracks the test count watermark and raises a
// sticky alert once the failure total reaches its threshold
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module ht_alert_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ht_pkg::ht_status_t status_i,
  input  logic               active_i,
  input  logic               clear_i,
  input  ht_pkg::reg_val_t   alert_thresh_i,
  output ht_pkg::reg_val_t   fail_total_o,
  output ht_pkg::reg_val_t   watermark_o,
  output logic               alert_o
);

  import ht_pkg::*;

  reg_val_t     fail_total_d, fail_total_q;
  reg_val_t     watermark_d, watermark_q;
  alert_state_e state_d, state_q;
  logic         restart;

  assign restart = !active_i || clear_i;

  // Saturating failure total
  always_comb begin
    fail_total_d = fail_total_q;
    if (restart) begin
      fail_total_d = '0;
    end else if (status_i.fail_pulse && (fail_total_q != '1)) begin
      fail_total_d = fail_total_q + 1'b1;
    end
  end

  // High watermark, one cycle behind test_cnt
  always_comb begin
    watermark_d = watermark_q;
    if (restart) begin
      watermark_d = '0;
    end else if (status_i.test_cnt > watermark_q) begin
      watermark_d = status_i.test_cnt;
    end
  end

  // Sticky alert FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      ALERT_IDLE: begin
        if (!restart && (status_i.count_err || (fail_total_d >= alert_thresh_i))) begin
          state_d = ALERT_FIRED;
        end
      end
      ALERT_FIRED: begin
        if (restart) begin
          state_d = ALERT_IDLE;
        end
      end
      default: state_d = ALERT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fail_total_q <= '0;
      watermark_q  <= '0;
      state_q      <= ALERT_IDLE;
    end else begin
      fail_total_q <= fail_total_d;
      watermark_q  <= watermark_d;
      state_q      <= state_d;
    end
  end

  assign fail_total_o = fail_total_q;
  assign watermark_o  = watermark_q;
  assign alert_o      = (state_q == ALERT_FIRED);

  // The alert only fires out of an active cycle
  a_alert_while_active: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(alert_o) |-> $past(active_i)
  ) else $error("alert raised while the test was inactive");

endmodule

`default_nettype wire

// ==== logic/ht_top.sv ====
// ==========================================================================
// Health test top level
// Repetition-count test feeding the failure alert control
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

module ht_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  ht_pkg::rng_sample_t sample_i,
  input  logic                active_i,
  input  logic                clear_i,
  input  ht_pkg::reg_val_t    repcnt_thresh_i,
  input  ht_pkg::reg_val_t    alert_thresh_i,
  output ht_pkg::ht_status_t  status_o,
  output ht_pkg::reg_val_t    fail_total_o,
  output ht_pkg::reg_val_t    watermark_o,
  output logic                alert_o
);

  // Status goes out and into the alert control on the same net
  ht_repcnt u_repcnt (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sample_i  (sample_i),
    .active_i  (active_i),
    .clear_i   (clear_i),
    .thresh_i  (repcnt_thresh_i),
    .status_o  (status_o)
  );

  ht_alert_ctrl u_alert_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .status_i       (status_o),
    .active_i       (active_i),
    .clear_i        (clear_i),
    .alert_thresh_i (alert_thresh_i),
    .fail_total_o   (fail_total_o),
    .watermark_o    (watermark_o),
    .alert_o        (alert_o)
  );

endmodule

`default_nettype wire

// ==== sim/ht_tb.sv ====
// ==========================================================================
// Health test testbench
// Directed and xorshift stimulus for the repetition-count test and alert
// control, checked every cycle against a reference model
// ==========================================================================

`timescale 1ns/100ps
`default_nettype none

`include "ht_macros.svh"

module ht_tb;

  import ht_pkg::*;

  localparam int ClkPeriod    = 100;
  localparam int DriveDelay   = 10;
  localparam int RandStrobes  = 60;
  // Worst case cycles of reset and of each test in order
  localparam int TestCycles   = 4 + 2 + 16 + (2 * RandStrobes * 4 + 2) + 15 + 12 + 27;
  localparam int MarginCycles = 200;

  // Reference model state stepped once per clock edge
  typedef struct packed {
    rng_bits_t  prev;
    lane_cnts_t cnt;
    logic       strobe;
    reg_val_t   fail_total;
    reg_val_t   watermark;
    logic       alert;
  } ref_state_t;

  logic        clk_i;
  logic        rst_ni;
  rng_sample_t sample_i;
  logic        active_i;
  logic        clear_i;
  reg_val_t    repcnt_thresh_i;
  reg_val_t    alert_thresh_i;
  ht_status_t  status_o;
  reg_val_t    fail_total_o;
  reg_val_t    watermark_o;
  logic        alert_o;

  ref_state_t  ref_q;
  logic [31:0] rng_state;
  int          err_cnt;
  int          test_err_start;
  int          tests_passed;
  int          tests_failed;
  int          pulse_cnt;
  int          pulses_before;
  logic        count_err_seen;

  ht_top ht_top_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sample_i        (sample_i),
    .active_i        (active_i),
    .clear_i         (clear_i),
    .repcnt_thresh_i (repcnt_thresh_i),
    .alert_thresh_i  (alert_thresh_i),
    .status_o        (status_o),
    .fail_total_o    (fail_total_o),
    .watermark_o     (watermark_o),
    .alert_o         (alert_o)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic reg_val_t max_lane_count(input lane_cnts_t c);
    reg_val_t m;
    m = c[0];
    for (int i = 1; i < `RNG_BUS_WIDTH; i++) begin
      if (c[i] > m) m = c[i];
    end
    return m;
  endfunction

  // Pulse in the cycle after a strobe once any lane hits the threshold
  function automatic logic predict_pulse(input ref_state_t s, input logic active,
                                         input reg_val_t thresh);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `RNG_BUS_WIDTH; i++) begin
      if (s.cnt[i] >= thresh) hit = 1'b1;
    end
    return active && s.strobe && hit;
  endfunction

  function automatic ref_state_t step_reference(input ref_state_t s, input rng_sample_t smp,
                                                input logic active, input logic clear,
                                                input reg_val_t rthresh,
                                                input reg_val_t athresh);
    ref_state_t nxt;
    logic       restart;
    nxt     = s;
    restart = !active || clear;
    nxt.strobe = smp.valid;
    for (int i = 0; i < `RNG_BUS_WIDTH; i++) begin
      if (restart) begin
        nxt.cnt[i] = 16'd1;
      end else if (smp.valid && (smp.bits[i] != s.prev[i])) begin
        nxt.cnt[i] = 16'd1;
      end else if (smp.valid && (s.cnt[i] != 16'hffff)) begin
        nxt.cnt[i] = s.cnt[i] + 16'd1;
      end
    end
    if (restart) begin
      nxt.prev       = '0;
      nxt.fail_total = '0;
      nxt.watermark  = '0;
      nxt.alert      = 1'b0;
    end else begin
      if (smp.valid) nxt.prev = smp.bits;
      if (predict_pulse(s, active, rthresh) && (s.fail_total != 16'hffff)) begin
        nxt.fail_total = s.fail_total + 16'd1;
      end
      if (max_lane_count(s.cnt) > s.watermark) nxt.watermark = max_lane_count(s.cnt);
      if (nxt.fail_total >= athresh) nxt.alert = 1'b1;
    end
    return nxt;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic flag_mismatch(input string name, input reg_val_t got, input reg_val_t exp);
    $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  task automatic begin_test();
    test_err_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_start) begin
      $display("test %s: passed", name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", name, err_cnt - test_err_start);
      tests_failed++;
    end
  endtask

  // One strobe followed by gap cycles with valid low
  task automatic send_sample(input rng_bits_t bits, input int gap);
    sample_i = {1'b1, bits};
    next_cycle();
    sample_i.valid = 1'b0;
    repeat (gap) next_cycle();
  endtask

  task automatic pulse_clear();
    clear_i = 1'b1;
    next_cycle();
    clear_i = 1'b0;
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      ref_q <= '0;
    end else begin
      ref_q <= step_reference(ref_q, sample_i, active_i, clear_i, repcnt_thresh_i,
                              alert_thresh_i);
    end
  end

  // Compare on the falling edge where inputs and outputs are settled
  always @(negedge clk_i) begin : compare_outputs
    reg_val_t exp_cnt;
    logic     exp_pulse;
    if (rst_ni) begin
      exp_cnt   = max_lane_count(ref_q.cnt);
      exp_pulse = predict_pulse(ref_q, active_i, repcnt_thresh_i);
      if (status_o.test_cnt !== exp_cnt)
        flag_mismatch("status_o.test_cnt", status_o.test_cnt, exp_cnt);
      if (status_o.fail_pulse !== exp_pulse)
        flag_mismatch("status_o.fail_pulse", reg_val_t'(status_o.fail_pulse),
                      reg_val_t'(exp_pulse));
      if (fail_total_o !== ref_q.fail_total)
        flag_mismatch("fail_total_o", fail_total_o, ref_q.fail_total);
      if (watermark_o !== ref_q.watermark)
        flag_mismatch("watermark_o", watermark_o, ref_q.watermark);
      if (alert_o !== ref_q.alert)
        flag_mismatch("alert_o", reg_val_t'(alert_o), reg_val_t'(ref_q.alert));
      if (status_o.fail_pulse === 1'b1) pulse_cnt++;
      if (status_o.count_err !== 1'b0) begin
        flag_mismatch("status_o.count_err", reg_val_t'(status_o.count_err), '0);
        count_err_seen = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #((TestCycles + MarginCycles) * ClkPeriod);
    $display("Timeout: tests did not finish within %0d cycles", TestCycles + MarginCycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_ni          = 1'b0;
    sample_i        = '0;
    active_i        = 1'b0;
    clear_i         = 1'b0;
    repcnt_thresh_i = 16'hffff;
    alert_thresh_i  = 16'hffff;
    rng_state       = 32'd67;
    err_cnt         = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    pulse_cnt       = 0;
    count_err_seen  = 1'b0;
    repeat (4) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    begin_test();
    repeat (2) next_cycle();
    if (status_o.test_cnt !== 16'd1) flag_mismatch("status_o.test_cnt", status_o.test_cnt, 16'd1);
    if (status_o.fail_pulse !== 1'b0)
      flag_mismatch("status_o.fail_pulse", reg_val_t'(status_o.fail_pulse), '0);
    if (status_o.count_err !== 1'b0)
      flag_mismatch("status_o.count_err", reg_val_t'(status_o.count_err), '0);
    if (alert_o !== 1'b0) flag_mismatch("alert_o", reg_val_t'(alert_o), '0);
    if (fail_total_o !== '0) flag_mismatch("fail_total_o", fail_total_o, '0);
    if (watermark_o !== '0) flag_mismatch("watermark_o", watermark_o, '0);
    end_test("reset and idle");

    // Lane 0 stuck at one while the other lanes toggle
    begin_test();
    active_i        = 1'b1;
    repcnt_thresh_i = 16'd5;
    pulses_before   = pulse_cnt;
    for (int k = 1; k <= 8; k++) begin
      send_sample({k[0] ? 3'b111 : 3'b000, 1'b1}, 0);
      if (status_o.test_cnt !== reg_val_t'(k))
        flag_mismatch("status_o.test_cnt", status_o.test_cnt, reg_val_t'(k));
      if (status_o.fail_pulse !== (k >= 5))
        flag_mismatch("status_o.fail_pulse", reg_val_t'(status_o.fail_pulse),
                      reg_val_t'(k >= 5));
      next_cycle();
    end
    if (pulse_cnt - pulses_before != 4) begin
      $display("Stuck lane gave %0d failure pulses instead of 4", pulse_cnt - pulses_before);
      err_cnt++;
    end
    end_test("stuck lane");

    // Biased random bits with irregular strobe gaps
    begin_test();
    pulse_clear();
    repcnt_thresh_i = 16'd3;
    for (int n = 0; n < 2 * RandStrobes; n++) begin
      if (n == RandStrobes) begin
        repcnt_thresh_i = 16'hffff;
        pulses_before   = pulse_cnt;
      end
      rng_state = xorshift32(rng_state);
      send_sample(rng_state[3:0] & rng_state[7:4], int'(rng_state[9:8]));
    end
    next_cycle();
    if (pulse_cnt != pulses_before) begin
      $display("Random data with a high threshold gave %0d failure pulses",
               pulse_cnt - pulses_before);
      err_cnt++;
    end
    end_test("random data");

    begin_test();
    repcnt_thresh_i = 16'd2;
    alert_thresh_i  = 16'd3;
    pulse_clear();
    for (int n = 1; n <= 5; n++) begin
      send_sample('0, 0);
      if (status_o.fail_pulse !== 1'b1)
        flag_mismatch("status_o.fail_pulse", reg_val_t'(status_o.fail_pulse), 16'd1);
      if (alert_o !== (n > 3)) flag_mismatch("alert_o", reg_val_t'(alert_o), reg_val_t'(n > 3));
      next_cycle();
      if (fail_total_o !== reg_val_t'(n))
        flag_mismatch("fail_total_o", fail_total_o, reg_val_t'(n));
      if (alert_o !== (n >= 3)) flag_mismatch("alert_o", reg_val_t'(alert_o), reg_val_t'(n >= 3));
    end
    repeat (4) next_cycle();
    if (alert_o !== 1'b1) flag_mismatch("alert_o", reg_val_t'(alert_o), 16'd1);
    end_test("alert");

    begin_test();
    pulse_clear();
    if (status_o.test_cnt !== 16'd1) flag_mismatch("status_o.test_cnt", status_o.test_cnt, 16'd1);
    if (fail_total_o !== '0) flag_mismatch("fail_total_o", fail_total_o, '0);
    if (watermark_o !== '0) flag_mismatch("watermark_o", watermark_o, '0);
    if (alert_o !== 1'b0) flag_mismatch("alert_o", reg_val_t'(alert_o), '0);
    repeat (3) send_sample('0, 1);
    if (alert_o !== 1'b1) flag_mismatch("alert_o", reg_val_t'(alert_o), 16'd1);
    active_i = 1'b0;
    next_cycle();
    if (fail_total_o !== '0) flag_mismatch("fail_total_o", fail_total_o, '0);
    if (watermark_o !== '0) flag_mismatch("watermark_o", watermark_o, '0);
    if (alert_o !== 1'b0) flag_mismatch("alert_o", reg_val_t'(alert_o), '0);
    for (int n = 0; n < 4; n++) begin
      send_sample('0, 0);
      if (status_o.fail_pulse !== 1'b0)
        flag_mismatch("status_o.fail_pulse", reg_val_t'(status_o.fail_pulse), '0);
      if (status_o.test_cnt !== 16'd1)
        flag_mismatch("status_o.test_cnt", status_o.test_cnt, 16'd1);
    end
    end_test("clear and deactivate");

    // All lanes stuck at zero for eleven strobes before a toggle
    begin_test();
    active_i        = 1'b1;
    repcnt_thresh_i = 16'hffff;
    alert_thresh_i  = 16'hffff;
    pulse_clear();
    repeat (11) send_sample('0, 1);
    if (status_o.test_cnt !== 16'd12) flag_mismatch("status_o.test_cnt", status_o.test_cnt, 16'd12);
    send_sample(4'hf, 1);
    send_sample(4'h0, 1);
    if (status_o.test_cnt !== 16'd1) flag_mismatch("status_o.test_cnt", status_o.test_cnt, 16'd1);
    if (watermark_o !== 16'd12) flag_mismatch("watermark_o", watermark_o, 16'd12);
    if (count_err_seen) begin
      $display("Counter copy mismatch reported on status_o.count_err during the run");
      err_cnt++;
    end
    end_test("watermark and count error");

    $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, err_cnt);
    if ((tests_failed == 0) && (err_cnt == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/ht_pkg.sv
logic/ht_hardened_counter.sv
logic/ht_max_tree.sv
logic/ht_repcnt.sv
logic/ht_alert_ctrl.sv
logic/ht_top.sv
sim/ht_tb.sv

// ==== Makefile ====
# Verilator build and run of the health test testbench

LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vht_tb: sources.f logic/*.sv logic/*.svh sim/*.sv
	verilator --binary --timing --assert -f sources.f --top-module ht_tb -o Vht_tb

run: obj_dir/Vht_tb
	./obj_dir/Vht_tb > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module ht_tb

clean:
	rm -rf obj_dir $(LOG)
